//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -j 0
TOP = tbMipsCore
FILELIST = verilog.f
BUILDDIR = obj_dir

SIM = $(BUILDDIR)/V$(TOP)
SOURCES = $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard verif/*.svh) $(FILELIST)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR)

//--- source/decExIf.sv
`timescale 1ns/1ps

interface decExIf;

	// control decoded in decode
	logic regWrite;
	logic memToReg;
	logic memWrite;
	// immediate as second alu operand
	logic aluSrc;
	// destination is rd, not rt
	logic regDst;
	mipsPkg::aluOp alu;

	// register file reads and immediate
	mipsPkg::word srcA;
	mipsPkg::word srcB;
	mipsPkg::word signImm;

	// register numbers
	mipsPkg::regNum rs;
	mipsPkg::regNum rt;
	mipsPkg::regNum rd;

	// decode side drives the bundle
	modport decode (
		output regWrite, memToReg, memWrite, aluSrc, regDst, alu,
		output srcA, srcB, signImm, rs, rt, rd
	);

	// execute side registers it
	modport execute (
		input regWrite, memToReg, memWrite, aluSrc, regDst, alu,
		input srcA, srcB, signImm, rs, rt, rd
	);

	// source registers only, for forwarding
	modport hazard (input rs, rt);

endinterface

//--- source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic flush,
	input mipsPkg::word pcF,
	input mipsPkg::word instrF,
	// compare operands from memory stage
	input logic fwdA,
	input logic fwdB,
	input mipsPkg::word aluOutM,
	// writeback port of the register file
	input logic regWriteW,
	input mipsPkg::regNum writeRegW,
	input mipsPkg::word resultW,
	output logic pcSrc,
	output logic jump,
	output logic branch,
	output mipsPkg::word branchTarget,
	output mipsPkg::word jumpTarget,
	output mipsPkg::regNum rsD,
	output mipsPkg::regNum rtD,
	decExIf.decode ex
);

	mipsPkg::word instrD;
	mipsPkg::word pcPlus4D;
	mipsPkg::word regFile [32];
	mipsPkg::word rdA;
	mipsPkg::word rdB;
	mipsPkg::opcode op;
	mipsPkg::funct fn;
	mipsPkg::word cmpA;
	mipsPkg::word cmpB;

	//////////////////////////////
	// fetch/decode register
	//////////////////////////////

	// held on stall, squashed behind a taken branch or jump
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrD <= '0;
			pcPlus4D <= '0;
		end else if (!stall) begin
			instrD <= flush ? '0 : instrF;
			pcPlus4D <= pcF + 32'd4;
		end
	end

	assign op = instrD[31:26];
	assign fn = instrD[5:0];
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];

	//////////////////////////////
	// register file
	//////////////////////////////

	// register 0 is never written
	always_ff @(posedge clk) begin
		if (regWriteW && writeRegW != '0) begin
			regFile[writeRegW] <= resultW;
		end
	end

	// write-through bypass from writeback
	assign rdA = (rsD == '0) ? '0 : (regWriteW && writeRegW == rsD) ? resultW : regFile[rsD];
	assign rdB = (rtD == '0) ? '0 : (regWriteW && writeRegW == rtD) ? resultW : regFile[rtD];

	// control decode
	always_comb begin
		ex.regWrite = 1'b0;
		ex.memToReg = 1'b0;
		ex.memWrite = 1'b0;
		ex.aluSrc = 1'b0;
		ex.regDst = 1'b0;
		ex.alu = mipsPkg::aluAdd;
		branch = 1'b0;
		jump = 1'b0;
		case (op)
			mipsPkg::opRtype: begin
				ex.regDst = 1'b1;
				// unknown funct, incl. the all-zero bubble, writes nothing
				ex.regWrite = (fn == mipsPkg::fnAdd) || (fn == mipsPkg::fnSub) ||
					(fn == mipsPkg::fnAnd) || (fn == mipsPkg::fnOr) || (fn == mipsPkg::fnSlt);
				case (fn)
					mipsPkg::fnSub: ex.alu = mipsPkg::aluSub;
					mipsPkg::fnAnd: ex.alu = mipsPkg::aluAnd;
					mipsPkg::fnOr: ex.alu = mipsPkg::aluOr;
					mipsPkg::fnSlt: ex.alu = mipsPkg::aluSlt;
					default: ex.alu = mipsPkg::aluAdd;
				endcase
			end
			mipsPkg::opAddi: begin
				ex.regWrite = 1'b1;
				ex.aluSrc = 1'b1;
			end
			mipsPkg::opLw: begin
				ex.regWrite = 1'b1;
				ex.memToReg = 1'b1;
				ex.aluSrc = 1'b1;
			end
			mipsPkg::opSw: begin
				ex.memWrite = 1'b1;
				ex.aluSrc = 1'b1;
			end
			mipsPkg::opBeq: branch = 1'b1;
			mipsPkg::opJ: jump = 1'b1;
			default: ;
		endcase
	end

	// operands and immediate toward execute
	assign ex.srcA = rdA;
	assign ex.srcB = rdB;
	assign ex.signImm = {{16{instrD[15]}}, instrD[15:0]};
	assign ex.rs = rsD;
	assign ex.rt = rtD;
	assign ex.rd = instrD[15:11];

	// targets
	assign branchTarget = pcPlus4D + {ex.signImm[29:0], 2'b00};
	assign jumpTarget = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// beq resolved here, alu result forwarded from memory
	assign cmpA = fwdA ? aluOutM : rdA;
	assign cmpB = fwdB ? aluOutM : rdB;
	assign pcSrc = branch && (cmpA == cmpB);

	// a write aimed at register 0 must not stick
	zeroReg: assert property (
		@(posedge clk) disable iff (!rstN)
		(regWriteW && writeRegW == '0) |=> (rsD != '0 || ex.srcA == '0)
	);

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rstN,
	// bubble into execute
	input logic flush,
	decExIf.execute ex,
	input mipsPkg::fwdSel fwdA,
	input mipsPkg::fwdSel fwdB,
	output mipsPkg::regNum writeRegE,
	output mipsPkg::regNum writeRegM,
	output mipsPkg::regNum writeRegW,
	output logic regWriteE,
	output logic memToRegE,
	output logic regWriteM,
	output logic memToRegM,
	output logic regWriteW,
	output mipsPkg::word aluOutM,
	output mipsPkg::word resultW,
	output mipsPkg::word dataAddr,
	output mipsPkg::word dataWrite,
	output logic dataWe,
	input mipsPkg::word dataRead
);

	logic memWriteE, aluSrcE, regDstE, memWriteM, memToRegW;
	mipsPkg::aluOp aluE;
	mipsPkg::fwdSel fwdAE, fwdBE;
	mipsPkg::word srcAE, srcBE, signImmE, aluA, fwdValB, aluB, aluOutE;
	mipsPkg::word writeDataM, aluOutW, readDataW;
	mipsPkg::regNum rtE, rdE;

	// decode/execute register
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			{regWriteE, memToRegE, memWriteE, aluSrcE, regDstE} <= '0;
			aluE <= mipsPkg::aluAdd;
			{fwdAE, fwdBE} <= {mipsPkg::fwdNone, mipsPkg::fwdNone};
			{srcAE, srcBE, signImmE, rtE, rdE} <= '0;
		end else begin
			{regWriteE, memToRegE, memWriteE} <= {ex.regWrite, ex.memToReg, ex.memWrite};
			{aluSrcE, regDstE, aluE} <= {ex.aluSrc, ex.regDst, ex.alu};
			{fwdAE, fwdBE} <= {fwdA, fwdB};
			{srcAE, srcBE, signImmE, rtE, rdE} <= {ex.srcA, ex.srcB, ex.signImm, ex.rt, ex.rd};
		end
	end

	// operand forwarding, memory before writeback
	assign aluA = (fwdAE == mipsPkg::fwdMem) ? aluOutM : (fwdAE == mipsPkg::fwdWb) ? resultW : srcAE;
	assign fwdValB = (fwdBE == mipsPkg::fwdMem) ? aluOutM : (fwdBE == mipsPkg::fwdWb) ? resultW : srcBE;
	assign aluB = aluSrcE ? signImmE : fwdValB;
	assign writeRegE = regDstE ? rdE : rtE;

	// alu
	always_comb begin
		case (aluE)
			mipsPkg::aluSub: aluOutE = aluA - aluB;
			mipsPkg::aluAnd: aluOutE = aluA & aluB;
			mipsPkg::aluOr: aluOutE = aluA | aluB;
			mipsPkg::aluSlt: aluOutE = {31'b0, $signed(aluA) < $signed(aluB)};
			default: aluOutE = aluA + aluB;
		endcase
	end

	//////////////////////////////
	// memory and writeback
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			{regWriteM, memToRegM, memWriteM, aluOutM, writeDataM, writeRegM} <= '0;
			{regWriteW, memToRegW, aluOutW, readDataW, writeRegW} <= '0;
		end else begin
			{regWriteM, memToRegM, memWriteM} <= {regWriteE, memToRegE, memWriteE};
			{aluOutM, writeDataM, writeRegM} <= {aluOutE, fwdValB, writeRegE};
			{regWriteW, memToRegW, writeRegW} <= {regWriteM, memToRegM, writeRegM};
			{aluOutW, readDataW} <= {aluOutM, dataRead};
		end
	end

	// data memory port
	assign dataAddr = aluOutM;
	assign dataWrite = writeDataM;
	assign dataWe = memWriteM;

	// loaded data or alu result
	assign resultW = memToRegW ? readDataW : aluOutW;

	// store enable always resolved once out of reset
	weKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(dataWe));

endmodule

//--- source/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
	input logic clk,
	input logic rstN,
	// hold pc on hazard
	input logic stall,
	// taken beq from decode
	input logic pcSrc,
	input logic jump,
	input mipsPkg::word branchTarget,
	input mipsPkg::word jumpTarget,
	output mipsPkg::word pc
);

	mipsPkg::word pcPlus4;
	mipsPkg::word pcNext;

	// sequential fetch
	assign pcPlus4 = pc + 32'd4;

	// next pc, jump wins over branch
	always_comb begin
		if (jump) begin
			pcNext = jumpTarget;
		end else if (pcSrc) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pcPlus4;
		end
	end

	// pc register, frozen while stalled
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= mipsPkg::resetPc;
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

	// targets from decode keep word alignment
	pcAligned: assert property (
		@(posedge clk) disable iff (!rstN)
		pc[1:0] == 2'b00
	);

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input mipsPkg::regNum rsD,
	input mipsPkg::regNum rtD,
	input logic branchD,
	decExIf.hazard ex,
	input mipsPkg::regNum writeRegE,
	input mipsPkg::regNum writeRegM,
	input mipsPkg::regNum writeRegW,
	input logic regWriteE,
	input logic memToRegE,
	input logic regWriteM,
	input logic memToRegM,
	input logic regWriteW,
	output mipsPkg::fwdSel fwdAE,
	output mipsPkg::fwdSel fwdBE,
	output logic fwdAD,
	output logic fwdBD,
	output logic stall,
	output logic flushE
);

	logic matchE;
	logic matchM;
	logic lwStall;
	logic branchStall;

	// selects are taken in decode and registered with the operation;
	// a writer now in E sits in M next cycle, one now in M sits in W
	always_comb begin
		fwdAE = mipsPkg::fwdNone;
		fwdBE = mipsPkg::fwdNone;
		if (ex.rs != '0 && regWriteE && writeRegE == ex.rs) fwdAE = mipsPkg::fwdMem;
		else if (ex.rs != '0 && regWriteM && writeRegM == ex.rs) fwdAE = mipsPkg::fwdWb;
		if (ex.rt != '0 && regWriteE && writeRegE == ex.rt) fwdBE = mipsPkg::fwdMem;
		else if (ex.rt != '0 && regWriteM && writeRegM == ex.rt) fwdBE = mipsPkg::fwdWb;
	end

	// beq compare only sees memory stage
	assign fwdAD = (rsD != '0) && regWriteM && (writeRegM == rsD);
	assign fwdBD = (rtD != '0) && regWriteM && (writeRegM == rtD);

	//////////////////////////////
	// stalls
	//////////////////////////////

	// only E and M producers matter here
	// writeback reaches decode through the register file bypass
	assign matchE = (writeRegE == rsD) || (writeRegE == rtD);
	assign matchM = (writeRegM == rsD) || (writeRegM == rtD);

	// load result not ready for execute
	assign lwStall = memToRegE && matchE;
	// beq waits for an alu result in E, or a load in E then M
	assign branchStall = branchD && ((regWriteE && matchE) || (memToRegM && matchM));

	// hold fetch and decode, bubble into execute
	assign stall = lwStall || branchStall;
	assign flushE = stall;

	// a held decode stage always leaves a bubble in execute
	always_comb begin
		assert final (!stall || flushE);
	end

endmodule

//--- source/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
	input logic clk,
	input logic rstN,
	// instruction memory
	output mipsPkg::word instrAddr,
	input mipsPkg::word instr,
	// data memory
	output mipsPkg::word dataAddr,
	output mipsPkg::word dataWrite,
	output logic dataWe,
	input mipsPkg::word dataRead
);

	logic stall, flushE, pcSrcD, jumpD, branchD, fwdAD, fwdBD;
	logic regWriteE, memToRegE, regWriteM, memToRegM, regWriteW;
	mipsPkg::word branchTargetD, jumpTargetD, aluOutM, resultW;
	mipsPkg::regNum rsD, rtD, writeRegE, writeRegM, writeRegW;
	mipsPkg::fwdSel fwdAE, fwdBE;

	// decode to execute bundle
	decExIf exBus ();

	fetchStage fetch (
		.clk(clk), .rstN(rstN), .stall(stall), .pcSrc(pcSrcD), .jump(jumpD),
		.branchTarget(branchTargetD), .jumpTarget(jumpTargetD), .pc(instrAddr)
	);

	// slot behind a redirect is squashed
	decodeStage decode (
		.clk(clk), .rstN(rstN), .stall(stall), .flush(pcSrcD | jumpD),
		.pcF(instrAddr), .instrF(instr), .fwdA(fwdAD), .fwdB(fwdBD), .aluOutM(aluOutM),
		.regWriteW(regWriteW), .writeRegW(writeRegW), .resultW(resultW),
		.pcSrc(pcSrcD), .jump(jumpD), .branch(branchD),
		.branchTarget(branchTargetD), .jumpTarget(jumpTargetD),
		.rsD(rsD), .rtD(rtD), .ex(exBus.decode)
	);

	hazardUnit hazard (
		.rsD(rsD), .rtD(rtD), .branchD(branchD), .ex(exBus.hazard),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.regWriteE(regWriteE), .memToRegE(memToRegE), .regWriteM(regWriteM),
		.memToRegM(memToRegM), .regWriteW(regWriteW),
		.fwdAE(fwdAE), .fwdBE(fwdBE), .fwdAD(fwdAD), .fwdBD(fwdBD),
		.stall(stall), .flushE(flushE)
	);

	executeStage execute (
		.clk(clk), .rstN(rstN), .flush(flushE), .ex(exBus.execute),
		.fwdA(fwdAE), .fwdB(fwdBE),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.regWriteE(regWriteE), .memToRegE(memToRegE), .regWriteM(regWriteM),
		.memToRegM(memToRegM), .regWriteW(regWriteW),
		.aluOutM(aluOutM), .resultW(resultW),
		.dataAddr(dataAddr), .dataWrite(dataWrite), .dataWe(dataWe), .dataRead(dataRead)
	);

endmodule

//--- source/mipsPkg.sv
package mipsPkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// data and address value
	typedef logic [31:0] word;
	// register index
	typedef logic [4:0] regNum;
	// instruction fields
	typedef logic [5:0] opcode;
	typedef logic [5:0] funct;

	//////////////////////////////
	// instruction encodings
	//////////////////////////////

	localparam opcode opRtype = 6'h00;
	localparam opcode opJ     = 6'h02;
	localparam opcode opBeq   = 6'h04;
	localparam opcode opAddi  = 6'h08;
	localparam opcode opLw    = 6'h23;
	localparam opcode opSw    = 6'h2b;

	// r-type funct codes
	localparam funct fnAdd = 6'h20;
	localparam funct fnSub = 6'h22;
	localparam funct fnAnd = 6'h24;
	localparam funct fnOr  = 6'h25;
	localparam funct fnSlt = 6'h2a;

	// alu operations, 3 bits
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp;

	// execute operand source
	typedef enum logic [1:0] {fwdNone = 2'b00, fwdWb = 2'b01, fwdMem = 2'b10} fwdSel;

	// first fetch address
	localparam word resetPc = 32'h0000_0000;

endpackage

//--- verif/tbPrograms.svh
//////////////////////////////
// test program
//////////////////////////////

// one word per address, from resetPc upward
task automatic loadProgram();
	// 0x00 alu chain, forwarded from memory, writeback and the register file bypass
	romWords.push_back(iTypeWord(mipsPkg::opAddi, 1, 0, 5));
	romWords.push_back(iTypeWord(mipsPkg::opAddi, 2, 0, 12));
	romWords.push_back(rTypeWord(mipsPkg::fnAdd, 3, 1, 2));
	romWords.push_back(rTypeWord(mipsPkg::fnSub, 4, 3, 1));
	romWords.push_back(rTypeWord(mipsPkg::fnAnd, 5, 4, 1));
	romWords.push_back(rTypeWord(mipsPkg::fnOr, 6, 5, 3));
	romWords.push_back(rTypeWord(mipsPkg::fnSlt, 7, 3, 6));
	romWords.push_back(iTypeWord(mipsPkg::opAddi, 8, 7, -3));
	// 0x20 store data forwarded straight from the addi
	romWords.push_back(iTypeWord(mipsPkg::opSw, 8, 0, 20));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 3, 0, 0));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 4, 0, 4));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 5, 0, 8));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 6, 0, 12));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 7, 0, 16));
	// 0x38 load-use
	romWords.push_back(iTypeWord(mipsPkg::opLw, 9, 0, 32));
	romWords.push_back(rTypeWord(mipsPkg::fnAdd, 10, 9, 1));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 10, 0, 24));
	// 0x44 beq on a fresh load, not taken
	romWords.push_back(iTypeWord(mipsPkg::opLw, 11, 0, 36));
	romWords.push_back(iTypeWord(mipsPkg::opBeq, 0, 11, 1));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 11, 0, 28));
	// 0x50 beq on the alu result just before, taken to 0x64
	romWords.push_back(iTypeWord(mipsPkg::opAddi, 12, 1, 2));
	romWords.push_back(iTypeWord(mipsPkg::opAddi, 13, 0, 7));
	romWords.push_back(iTypeWord(mipsPkg::opBeq, 13, 12, 2));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 1, 0, 40));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 2, 0, 44));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 13, 0, 48));
	// 0x68 jump over two stores
	romWords.push_back(jumpWord(32'h74));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 1, 0, 120));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 2, 0, 124));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 2, 0, 52));
	// 0x78 write to register 0, then store it
	romWords.push_back(iTypeWord(mipsPkg::opAddi, 0, 0, 9));
	romWords.push_back(iTypeWord(mipsPkg::opSw, 0, 0, 56));
	// 0x80 park
	romWords.push_back(jumpWord(32'h80));
endtask

// name, byte address, stored word; loads read ramFill, C0DE0000 plus the byte address
task automatic loadExpected();
	addStore("addi negative, store data from mem", 32'h14, 32'hFFFF_FFFE);
	addStore("add, operand from wb", 32'h00, 32'h0000_0011);
	addStore("sub, operand from mem", 32'h04, 32'h0000_000C);
	addStore("and", 32'h08, 32'h0000_0004);
	addStore("or, register file bypass", 32'h0C, 32'h0000_0015);
	addStore("slt", 32'h10, 32'h0000_0001);
	addStore("load-use add", 32'h18, 32'hC0DE_0025);
	addStore("beq not taken after lw", 32'h1C, 32'hC0DE_0024);
	addStore("beq taken after alu", 32'h30, 32'h0000_0007);
	addStore("jump target", 32'h34, 32'h0000_000C);
	addStore("register 0 stays zero", 32'h38, 32'h0000_0000);
endtask

//--- verif/tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore;

	// cycles allowed for the whole program to store
	localparam int storeTimeout = 500;
	// extra cycles in the parking loop to catch stray stores
	localparam int drainCycles = 20;

	logic clk;
	logic rstN;
	mipsPkg::word instrAddr;
	mipsPkg::word instr = '0;
	mipsPkg::word dataAddr;
	mipsPkg::word dataWrite;
	logic dataWe;
	mipsPkg::word dataRead = '0;

	// instruction rom and data ram
	mipsPkg::word romWords [$];
	mipsPkg::word ram [64];

	// expected stores, in program order
	string storeNames [$];
	mipsPkg::word storeAddrs [$];
	mipsPkg::word storeDatas [$];
	int storeCount = 0;
	int activeCycles = 0;

	mipsCore dut (
		.clk(clk), .rstN(rstN),
		.instrAddr(instrAddr), .instr(instr),
		.dataAddr(dataAddr), .dataWrite(dataWrite), .dataWe(dataWe), .dataRead(dataRead)
	);

	//////////////////////////////
	// instruction encoding
	//////////////////////////////

	function automatic mipsPkg::word rTypeWord(mipsPkg::funct fn, int rd, int rs, int rt);
		return {mipsPkg::opRtype, rs[4:0], rt[4:0], rd[4:0], 5'b00000, fn};
	endfunction

	function automatic mipsPkg::word iTypeWord(mipsPkg::opcode op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	// target is a byte address
	function automatic mipsPkg::word jumpWord(int target);
		return {mipsPkg::opJ, target[27:2]};
	endfunction

	// ram contents before the program runs, built from the byte address
	function automatic mipsPkg::word ramFill(logic [5:0] idx);
		return {16'hC0DE, 8'h00, idx, 2'b00};
	endfunction

	task automatic addStore(string name, mipsPkg::word addr, mipsPkg::word data);
		storeNames.push_back(name);
		storeAddrs.push_back(addr);
		storeDatas.push_back(data);
	endtask

	task automatic abortRun(string why);
		$display("TESTBENCH FAILED");
		$fatal(1, why);
	endtask

	`include "tbPrograms.svh"

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// memory models
	//////////////////////////////

	// both memories answer mid-cycle, so data is valid in the address's own cycle
	always @(negedge clk) begin
		int romIdx;
		romIdx = int'({2'b00, instrAddr[31:2]});
		// past the program reads as a nop
		if (romIdx < romWords.size()) begin
			instr <= romWords[romIdx];
		end else begin
			instr <= '0;
		end
		dataRead <= ram[dataAddr[7:2]];
	end

	// filled during reset, written at the edge when dataWe is high
	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 64; i++) begin
				ram[i[5:0]] <= ramFill(i[5:0]);
			end
		end else if (dataWe) begin
			ram[dataAddr[7:2]] <= dataWrite;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	always @(negedge clk) begin
		// reset and the first cycle out of it
		if (!rstN || activeCycles == 0) begin
			resetState: assert (dataWe == 1'b0 && instrAddr == mipsPkg::resetPc) else begin
				$display("FAILED reset: expected dataWe 0 pc %h, actual dataWe %b pc %h",
					mipsPkg::resetPc, dataWe, instrAddr);
				abortRun("reset state check failed");
			end
		end
		if (rstN) begin
			activeCycles <= activeCycles + 1;
		end
		// each store against the table, in order
		if (rstN && dataWe) begin
			extraStore: assert (storeCount < storeAddrs.size()) else begin
				$display("a store to address %h came after all expected stores", dataAddr);
				abortRun("unexpected store");
			end
			storeAddr: assert (dataAddr == storeAddrs[storeCount]) else begin
				$display("FAILED %s address: expected %h, actual %h",
					storeNames[storeCount], storeAddrs[storeCount], dataAddr);
				abortRun("store address mismatch");
			end
			storeData: assert (dataWrite == storeDatas[storeCount]) else begin
				$display("FAILED %s data: expected %h, actual %h",
					storeNames[storeCount], storeDatas[storeCount], dataWrite);
				abortRun("store data mismatch");
			end
			storeCount <= storeCount + 1;
		end
	end

	initial begin
		int waitCycles;
		waitCycles = 0;
		rstN <= 1'b0;
		loadProgram();
		loadExpected();
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		// until every expected store has been seen
		while (storeCount < storeAddrs.size() && waitCycles < storeTimeout) begin
			@(posedge clk);
			waitCycles++;
		end
		if (storeCount == storeAddrs.size()) begin
			// core parks in its jump loop, any late store still hits the checker
			repeat (drainCycles) @(posedge clk);
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("the stores did not arrive: %0d of %0d seen after %0d cycles",
				storeCount, storeAddrs.size(), waitCycles);
			abortRun("timeout waiting for stores");
		end
	end

endmodule

//--- verilog.f
+incdir+verif
source/mipsPkg.sv
source/decExIf.sv
source/fetchStage.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/mipsCore.sv
verif/tbMipsCore.sv
